/* src/vchess_ctrl_pkg.sv */
package vchess_ctrl_pkg;

   // AXI4-Lite bus
   localparam int AXI_ADDR_WIDTH = 12;
   localparam int AXI_DATA_WIDTH = 32;
   localparam int ADDR_LSB = 2; // Byte to word address shift
   localparam int REG_ADDR_WIDTH = AXI_ADDR_WIDTH - ADDR_LSB;

   // Chess encoding
   localparam int RANK_WIDTH = 32; // 8 squares of 4 bits
   localparam int NUM_RANKS = 8;
   localparam int BOARD_WIDTH = RANK_WIDTH * NUM_RANKS;
   localparam int MOVE_INDEX_WIDTH = 8;
   localparam int EVAL_WIDTH = 24;
   localparam int HALF_MOVE_WIDTH = 10;
   localparam int CASTLE_WIDTH = 4;
   localparam int EP_COL_WIDTH = 4;

   // Move in coordinate form, promotion piece on top
   localparam int UCI_WIDTH = 16;
   localparam int UCI_COORD_WIDTH = 3;
   localparam int UCI_NUM_COORDS = 4;
   localparam int UCI_PROMO_WIDTH = 4;
   localparam int NIBBLE_WIDTH = 4;

   // Word addresses
   localparam logic [REG_ADDR_WIDTH-1:0] REG_CONTROL = 10'd0;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_MOVE_INDEX = 10'd1;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_POSITION = 10'd2;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_HALF_MOVE = 10'd3;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_CAPTURE_ONLY = 10'd4;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_BOARD_BASE = 10'd8; // Rank n at base + n
   localparam logic [REG_ADDR_WIDTH-1:0] REG_EVAL = 10'd134;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_MOVE_COUNT = 10'd135;
   localparam logic [REG_ADDR_WIDTH-1:0] REG_UCI = 10'd139;

   // Position word fields
   localparam int POS_EP_LSB = 0;
   localparam int POS_CASTLE_LSB = 4;
   localparam int POS_WHITE_BIT = 8;

   // Control word, written side
   localparam int CTRL_NEW_BOARD_BIT = 0;
   localparam int CTRL_CLEAR_MOVES_BIT = 1;
   localparam int CTRL_SOFT_RESET_BIT = 31;

   // Control word, status side
   localparam int STAT_MOVES_READY_BIT = 2;
   localparam int STAT_MOVE_READY_BIT = 3;
   localparam int STAT_STALEMATE_BIT = 4;
   localparam int STAT_MATE_BIT = 5;
   localparam int STAT_IDLE_BIT = 7;

   localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* src/axi_write_capture.sv */
`timescale 1ns/1ps

module axi_write_capture
   import vchess_ctrl_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [AXI_DATA_WIDTH-1:0] wdata,
   input  logic                      wvalid,
   output logic                      wready,
   output logic [1:0]                bresp,
   output logic                      bvalid,
   input  logic                      bready,
   output logic                      wr_valid,
   output logic [REG_ADDR_WIDTH-1:0] wr_addr,
   output logic [AXI_DATA_WIDTH-1:0] wr_data
);

   logic                      aw_full; // Address slot occupied
   logic                      w_full; // Data slot occupied
   logic                      resp_pending;
   logic [REG_ADDR_WIDTH-1:0] addr_q;
   logic [AXI_DATA_WIDTH-1:0] data_q;

   // No new beats while a slot is taken or B is outstanding
   assign awready = ~aw_full & ~resp_pending;
   assign wready = ~w_full & ~resp_pending;

   // Both slots full issues the register write
   assign wr_valid = aw_full & w_full;
   assign wr_addr = addr_q;
   assign wr_data = data_q;

   assign bvalid = resp_pending;
   assign bresp = RESP_OKAY; // Never an error

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         aw_full <= 1'b0;
         w_full <= 1'b0;
         resp_pending <= 1'b0;
      end
      else if (wr_valid)
      begin
         aw_full <= 1'b0;
         w_full <= 1'b0;
         resp_pending <= 1'b1;
      end
      else
      begin
         if (awvalid && awready)
         begin
            aw_full <= 1'b1;
         end
         if (wvalid && wready)
         begin
            w_full <= 1'b1;
         end
         if (resp_pending && bready)
         begin
            resp_pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (awvalid && awready)
      begin
         addr_q <= awaddr[AXI_ADDR_WIDTH-1:ADDR_LSB]; // Word address
      end
      if (wvalid && wready)
      begin
         data_q <= wdata;
      end
   end

endmodule

/* src/ctrl_reg_bank.sv */
`timescale 1ns/1ps

module ctrl_reg_bank
   import vchess_ctrl_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wr_valid,
   input  logic [REG_ADDR_WIDTH-1:0]   wr_addr,
   input  logic [AXI_DATA_WIDTH-1:0]   wr_data,
   output logic                        new_board_valid,
   output logic                        clear_moves,
   output logic                        soft_reset,
   output logic [MOVE_INDEX_WIDTH-1:0] move_index,
   output logic                        white_to_move,
   output logic [CASTLE_WIDTH-1:0]     castle_mask,
   output logic [EP_COL_WIDTH-1:0]     en_passant_col,
   output logic [HALF_MOVE_WIDTH-1:0]  half_move,
   output logic                        capture_only,
   output logic [BOARD_WIDTH-1:0]      board
);

   // Control word and scalar fields
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         new_board_valid <= 1'b0;
         clear_moves <= 1'b0;
         soft_reset <= 1'b0;
         move_index <= '0;
         white_to_move <= 1'b0;
         castle_mask <= '0;
         en_passant_col <= '0;
         half_move <= '0;
         capture_only <= 1'b0;
      end
      else if (wr_valid)
      begin
         case (wr_addr)
            REG_CONTROL:
            begin
               // Held as levels, the host clears them
               new_board_valid <= wr_data[CTRL_NEW_BOARD_BIT];
               clear_moves <= wr_data[CTRL_CLEAR_MOVES_BIT];
               soft_reset <= wr_data[CTRL_SOFT_RESET_BIT];
            end
            REG_MOVE_INDEX:
            begin
               move_index <= wr_data[MOVE_INDEX_WIDTH-1:0];
            end
            REG_POSITION:
            begin
               en_passant_col <= wr_data[POS_EP_LSB +: EP_COL_WIDTH];
               castle_mask <= wr_data[POS_CASTLE_LSB +: CASTLE_WIDTH];
               white_to_move <= wr_data[POS_WHITE_BIT]; // 1 is white
            end
            REG_HALF_MOVE:
            begin
               half_move <= wr_data[HALF_MOVE_WIDTH-1:0];
            end
            REG_CAPTURE_ONLY:
            begin
               capture_only <= wr_data[0];
            end
            default:
            begin
               // Board ranks and unmapped words leave these alone
            end
         endcase
      end
   end

   // Board, one rank per word from REG_BOARD_BASE
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         board <= '0;
      end
      else if (wr_valid)
      begin
         for (int n = 0; n < NUM_RANKS; n++)
         begin
            if (wr_addr == REG_BOARD_BASE + REG_ADDR_WIDTH'(n))
            begin
               board[n*RANK_WIDTH +: RANK_WIDTH] <= wr_data[RANK_WIDTH-1:0];
            end
         end
      end
   end

endmodule

/* src/axi_read_responder.sv */
`timescale 1ns/1ps

module axi_read_responder
   import vchess_ctrl_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [AXI_ADDR_WIDTH-1:0]   araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [AXI_DATA_WIDTH-1:0]   rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   input  logic                        new_board_valid,
   input  logic                        clear_moves,
   input  logic                        soft_reset,
   input  logic [MOVE_INDEX_WIDTH-1:0] move_index,
   input  logic                        white_to_move,
   input  logic [CASTLE_WIDTH-1:0]     castle_mask,
   input  logic [EP_COL_WIDTH-1:0]     en_passant_col,
   input  logic [HALF_MOVE_WIDTH-1:0]  half_move,
   input  logic                        capture_only,
   input  logic [BOARD_WIDTH-1:0]      board,
   input  logic                        mg_idle,
   input  logic                        mg_moves_ready,
   input  logic                        mg_move_ready,
   input  logic                        mg_stalemate,
   input  logic                        mg_mate,
   input  logic [MOVE_INDEX_WIDTH-1:0] mg_move_count,
   input  logic [EVAL_WIDTH-1:0]       mg_eval,
   input  logic [UCI_WIDTH-1:0]        mg_uci
);

   logic [REG_ADDR_WIDTH-1:0] rd_addr;
   logic [AXI_DATA_WIDTH-1:0] rd_word;
   logic                      ar_fire;

   assign rd_addr = araddr[AXI_ADDR_WIDTH-1:ADDR_LSB];
   assign arready = ~rvalid | rready; // Slot frees as the beat leaves
   assign ar_fire = arvalid & arready;
   assign rresp = RESP_OKAY;

   always_comb
   begin
      rd_word = '0; // Unmapped words read 0
      case (rd_addr)
         REG_CONTROL:
         begin
            rd_word[CTRL_NEW_BOARD_BIT] = new_board_valid;
            rd_word[CTRL_CLEAR_MOVES_BIT] = clear_moves;
            rd_word[CTRL_SOFT_RESET_BIT] = soft_reset;
            rd_word[STAT_MOVES_READY_BIT] = mg_moves_ready;
            rd_word[STAT_MOVE_READY_BIT] = mg_move_ready;
            rd_word[STAT_STALEMATE_BIT] = mg_stalemate;
            rd_word[STAT_MATE_BIT] = mg_mate;
            rd_word[STAT_IDLE_BIT] = mg_idle;
         end
         REG_MOVE_INDEX: rd_word[MOVE_INDEX_WIDTH-1:0] = move_index;
         REG_POSITION:
         begin
            rd_word[POS_EP_LSB +: EP_COL_WIDTH] = en_passant_col;
            rd_word[POS_CASTLE_LSB +: CASTLE_WIDTH] = castle_mask;
            rd_word[POS_WHITE_BIT] = white_to_move;
         end
         REG_HALF_MOVE: rd_word[HALF_MOVE_WIDTH-1:0] = half_move;
         REG_CAPTURE_ONLY: rd_word[0] = capture_only;
         REG_EVAL: rd_word = {{(AXI_DATA_WIDTH-EVAL_WIDTH){mg_eval[EVAL_WIDTH-1]}}, mg_eval};
         REG_MOVE_COUNT: rd_word[MOVE_INDEX_WIDTH-1:0] = mg_move_count;
         REG_UCI:
         begin
            // One coordinate per nibble, promotion piece above
            for (int i = 0; i < UCI_NUM_COORDS; i++)
            begin
               rd_word[i*NIBBLE_WIDTH +: UCI_COORD_WIDTH] = mg_uci[i*UCI_COORD_WIDTH +: UCI_COORD_WIDTH];
            end
            rd_word[UCI_NUM_COORDS*NIBBLE_WIDTH +: UCI_PROMO_WIDTH] =
               mg_uci[UCI_NUM_COORDS*UCI_COORD_WIDTH +: UCI_PROMO_WIDTH];
         end
         default:
         begin
            for (int n = 0; n < NUM_RANKS; n++)
            begin
               if (rd_addr == REG_BOARD_BASE + REG_ADDR_WIDTH'(n))
               begin
                  rd_word[RANK_WIDTH-1:0] = board[n*RANK_WIDTH +: RANK_WIDTH];
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rvalid <= 1'b0;
      end
      else if (ar_fire)
      begin
         rvalid <= 1'b1;
      end
      else if (rready)
      begin
         rvalid <= 1'b0;
      end
   end

   // Word sampled at the AR edge, held until taken
   always_ff @(posedge clk)
   begin
      if (ar_fire)
      begin
         rdata <= rd_word;
      end
   end

endmodule

/* src/vchess_ctrl_top.sv */
`timescale 1ns/1ps

module vchess_ctrl_top
   import vchess_ctrl_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [AXI_ADDR_WIDTH-1:0]   awaddr,
   input  logic [2:0]                  awprot, // Accepted, not used
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [AXI_DATA_WIDTH-1:0]   wdata,
   input  logic [3:0]                  wstrb, // Whole word always written
   input  logic                        wvalid,
   output logic                        wready,
   output logic [1:0]                  bresp,
   output logic                        bvalid,
   input  logic                        bready,
   input  logic [AXI_ADDR_WIDTH-1:0]   araddr,
   input  logic [2:0]                  arprot, // Accepted, not used
   input  logic                        arvalid,
   output logic                        arready,
   output logic [AXI_DATA_WIDTH-1:0]   rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   output logic                        new_board_valid,
   output logic                        clear_moves,
   output logic                        soft_reset,
   output logic [MOVE_INDEX_WIDTH-1:0] move_index,
   output logic                        white_to_move,
   output logic [CASTLE_WIDTH-1:0]     castle_mask,
   output logic [EP_COL_WIDTH-1:0]     en_passant_col,
   output logic [HALF_MOVE_WIDTH-1:0]  half_move,
   output logic                        capture_only,
   output logic [BOARD_WIDTH-1:0]      board,
   input  logic                        mg_idle,
   input  logic                        mg_moves_ready,
   input  logic                        mg_move_ready,
   input  logic                        mg_stalemate,
   input  logic                        mg_mate,
   input  logic [MOVE_INDEX_WIDTH-1:0] mg_move_count,
   input  logic [EVAL_WIDTH-1:0]       mg_eval,
   input  logic [UCI_WIDTH-1:0]        mg_uci
);

   logic                      wr_valid;
   logic [REG_ADDR_WIDTH-1:0] wr_addr;
   logic [AXI_DATA_WIDTH-1:0] wr_data;

   axi_write_capture u_write_capture (
      .clk      (clk),
      .rst_n    (rst_n),
      .awaddr   (awaddr),
      .awvalid  (awvalid),
      .awready  (awready),
      .wdata    (wdata),
      .wvalid   (wvalid),
      .wready   (wready),
      .bresp    (bresp),
      .bvalid   (bvalid),
      .bready   (bready),
      .wr_valid (wr_valid),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   ctrl_reg_bank u_reg_bank (
      .clk             (clk),
      .rst_n           (rst_n),
      .wr_valid        (wr_valid),
      .wr_addr         (wr_addr),
      .wr_data         (wr_data),
      .new_board_valid (new_board_valid),
      .clear_moves     (clear_moves),
      .soft_reset      (soft_reset),
      .move_index      (move_index),
      .white_to_move   (white_to_move),
      .castle_mask     (castle_mask),
      .en_passant_col  (en_passant_col),
      .half_move       (half_move),
      .capture_only    (capture_only),
      .board           (board)
   );

   axi_read_responder u_read_responder (
      .clk             (clk),
      .rst_n           (rst_n),
      .araddr          (araddr),
      .arvalid         (arvalid),
      .arready         (arready),
      .rdata           (rdata),
      .rresp           (rresp),
      .rvalid          (rvalid),
      .rready          (rready),
      .new_board_valid (new_board_valid),
      .clear_moves     (clear_moves),
      .soft_reset      (soft_reset),
      .move_index      (move_index),
      .white_to_move   (white_to_move),
      .castle_mask     (castle_mask),
      .en_passant_col  (en_passant_col),
      .half_move       (half_move),
      .capture_only    (capture_only),
      .board           (board),
      .mg_idle         (mg_idle),
      .mg_moves_ready  (mg_moves_ready),
      .mg_move_ready   (mg_move_ready),
      .mg_stalemate    (mg_stalemate),
      .mg_mate         (mg_mate),
      .mg_move_count   (mg_move_count),
      .mg_eval         (mg_eval),
      .mg_uci          (mg_uci)
   );

endmodule

/* tb/vchess_ctrl_properties.sv */
`timescale 1ns/1ps

module vchess_ctrl_properties
   import vchess_ctrl_pkg::*;
(
   input logic                      clk,
   input logic                      rst_n,
   input logic                      awready,
   input logic                      wready,
   input logic                      bvalid,
   input logic                      bready,
   input logic                      rvalid,
   input logic                      rready,
   input logic [AXI_DATA_WIDTH-1:0] rdata
);

   int unsigned failures = 0; // Failed assertion count

   b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
   else
   begin
      failures++;
      $error("bvalid dropped before bready");
   end

   r_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata))
   else
   begin
      failures++;
      $error("rvalid or rdata changed before rready");
   end

   // Write slots stay closed while a response is outstanding
   no_accept_during_b: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid |-> !awready && !wready)
   else
   begin
      failures++;
      $error("awready or wready high while bvalid is high");
   end

endmodule

bind vchess_ctrl_top vchess_ctrl_properties u_properties (
   .clk     (clk),
   .rst_n   (rst_n),
   .awready (awready),
   .wready  (wready),
   .bvalid  (bvalid),
   .bready  (bready),
   .rvalid  (rvalid),
   .rready  (rready),
   .rdata   (rdata)
);

/* tb/tb_vchess_ctrl.sv */
`timescale 1ns/1ps

module tb_vchess_ctrl
   import vchess_ctrl_pkg::*;
();

   localparam int MAX_CYCLES = 2000; // About 75 transfers of at most 10 cycles, with margin

   logic                        clk = 1'b0;
   logic                        rst_n;
   logic [AXI_ADDR_WIDTH-1:0]   awaddr;
   logic [2:0]                  awprot;
   logic                        awvalid;
   logic                        awready;
   logic [AXI_DATA_WIDTH-1:0]   wdata;
   logic [3:0]                  wstrb;
   logic                        wvalid;
   logic                        wready;
   logic [1:0]                  bresp;
   logic                        bvalid;
   logic                        bready;
   logic [AXI_ADDR_WIDTH-1:0]   araddr;
   logic [2:0]                  arprot;
   logic                        arvalid;
   logic                        arready;
   logic [AXI_DATA_WIDTH-1:0]   rdata;
   logic [1:0]                  rresp;
   logic                        rvalid;
   logic                        rready;
   logic                        new_board_valid;
   logic                        clear_moves;
   logic                        soft_reset;
   logic [MOVE_INDEX_WIDTH-1:0] move_index;
   logic                        white_to_move;
   logic [CASTLE_WIDTH-1:0]     castle_mask;
   logic [EP_COL_WIDTH-1:0]     en_passant_col;
   logic [HALF_MOVE_WIDTH-1:0]  half_move;
   logic                        capture_only;
   logic [BOARD_WIDTH-1:0]      board;
   logic                        mg_idle;
   logic                        mg_moves_ready;
   logic                        mg_move_ready;
   logic                        mg_stalemate;
   logic                        mg_mate;
   logic [MOVE_INDEX_WIDTH-1:0] mg_move_count;
   logic [EVAL_WIDTH-1:0]       mg_eval;
   logic [UCI_WIDTH-1:0]        mg_uci;

   int value_errors = 0;
   int protocol_errors = 0;
   int cycles = 0;

   vchess_ctrl_top DUT (.*);

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, the tests did not complete", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   task automatic tick();
      @(posedge clk);
      #1; // Drive point after the edge
   endtask

   function automatic int rand_delay();
      return $urandom_range(3, 0);
   endfunction

   function automatic logic [31:0] rank_word(input int n);
      return 32'h1357_9BDF ^ (32'h1111_1111 * 32'(n + 1));
   endfunction

   function automatic logic [30:0] scalar_outputs();
      return {new_board_valid, clear_moves, soft_reset, move_index, white_to_move,
              castle_mask, en_passant_col, half_move, capture_only};
   endfunction

   task automatic check_value(input string name, input logic [BOARD_WIDTH-1:0] got,
                              input logic [BOARD_WIDTH-1:0] exp);
      assert (got === exp)
      else
      begin
         value_errors++;
         $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond === 1'b1)
      else
      begin
         protocol_errors++;
         $display("Protocol failure at %0t ns: %s", $time, what);
      end
   endtask

   // Order 0 sends AW and W together, 1 sends AW first, 2 sends W first
   task automatic axi_write(input logic [REG_ADDR_WIDTH-1:0] word, input logic [31:0] data,
                            input int order, input int bready_delay);
      logic aw_done;
      logic w_done;
      logic aw_fire;
      logic w_fire;
      aw_done = 1'b0;
      w_done = 1'b0;
      check_true(!bvalid, "write response pending before a new write");
      awaddr = {word, 2'b00};
      wdata = data;
      while (!(aw_done && w_done))
      begin
         awvalid = !aw_done && (order != 2 || w_done);
         wvalid = !w_done && (order != 1 || aw_done);
         #1;
         aw_fire = awvalid && awready;
         w_fire = wvalid && wready;
         tick();
         aw_done = aw_done || aw_fire;
         w_done = w_done || w_fire;
      end
      awvalid = 1'b0;
      wvalid = 1'b0;
      while (!bvalid)
         tick();
      repeat (bready_delay)
         tick();
      check_value("bresp", bresp, RESP_OKAY);
      bready = 1'b1;
      tick();
      bready = 1'b0;
      check_true(!bvalid, "bvalid still high after the write response handshake");
   endtask

   task automatic axi_read(input logic [REG_ADDR_WIDTH-1:0] word, input int rready_delay,
                           output logic [31:0] data);
      logic ar_fire;
      ar_fire = 1'b0;
      araddr = {word, 2'b00};
      arvalid = 1'b1;
      while (!ar_fire)
      begin
         #1;
         ar_fire = arready;
         tick();
      end
      arvalid = 1'b0;
      araddr = '1; // Later address must not reach rdata
      check_true(rvalid, "rvalid not high the cycle after the read address");
      repeat (rready_delay)
         tick();
      data = rdata;
      check_value("rresp", rresp, RESP_OKAY);
      rready = 1'b1;
      tick();
      rready = 1'b0;
      check_true(!rvalid, "rvalid still high after the read data handshake");
   endtask

   task automatic read_check(input logic [REG_ADDR_WIDTH-1:0] word, input logic [31:0] exp,
                             input string name);
      logic [31:0] data;
      axi_read(word, rand_delay(), data);
      check_value(name, data, exp);
   endtask

   task automatic test_reset();
      check_value("generator outputs", scalar_outputs(), '0);
      check_value("board", board, '0);
      read_check(REG_CONTROL, 32'h0, "rdata control");
      read_check(REG_POSITION, 32'h0, "rdata position");
      for (int n = 0; n < NUM_RANKS; n++)
         read_check(REG_BOARD_BASE + n, 32'h0, $sformatf("rdata rank %0d", n));
   endtask

   task automatic test_position_load();
      axi_write(REG_POSITION, 32'h0000_01B5, 0, rand_delay()); // White, castle 1011, ep 5
      axi_write(REG_HALF_MOVE, 32'd345, 1, rand_delay());
      axi_write(REG_MOVE_INDEX, 32'd42, 2, rand_delay());
      axi_write(REG_CAPTURE_ONLY, 32'd1, 0, rand_delay());
      for (int n = 0; n < NUM_RANKS; n++)
         axi_write(REG_BOARD_BASE + n, rank_word(n), n % 3, rand_delay());
      check_value("white_to_move", white_to_move, 1'b1);
      check_value("castle_mask", castle_mask, 4'b1011);
      check_value("en_passant_col", en_passant_col, 4'd5);
      check_value("half_move", half_move, 10'd345);
      check_value("move_index", move_index, 8'd42);
      check_value("capture_only", capture_only, 1'b1);
      check_value("board", board, {rank_word(7), rank_word(6), rank_word(5), rank_word(4),
                                   rank_word(3), rank_word(2), rank_word(1), rank_word(0)});
      read_check(REG_POSITION, 32'h0000_01B5, "rdata position");
      read_check(REG_HALF_MOVE, 32'd345, "rdata half move");
      read_check(REG_MOVE_INDEX, 32'd42, "rdata move index");
      read_check(REG_CAPTURE_ONLY, 32'd1, "rdata capture only");
      for (int n = 0; n < NUM_RANKS; n++)
         read_check(REG_BOARD_BASE + n, rank_word(n), $sformatf("rdata rank %0d", n));
   endtask

   task automatic test_control_status();
      axi_write(REG_CONTROL, 32'hFFFF_FFFF, 0, rand_delay()); // Only bits 0, 1, 31 stored
      check_value("control outputs", {soft_reset, clear_moves, new_board_valid}, 3'b111);
      mg_moves_ready = 1'b1;
      mg_stalemate = 1'b1;
      mg_idle = 1'b1;
      read_check(REG_CONTROL, 32'h8000_0097, "rdata control");
      axi_write(REG_CONTROL, 32'h0000_0001, 1, rand_delay());
      check_value("control outputs", {soft_reset, clear_moves, new_board_valid}, 3'b001);
      mg_moves_ready = 1'b0;
      mg_stalemate = 1'b0;
      mg_idle = 1'b0;
      mg_move_ready = 1'b1;
      mg_mate = 1'b1;
      read_check(REG_CONTROL, 32'h0000_0029, "rdata control");
      axi_write(REG_CONTROL, 32'h0, 2, rand_delay());
      mg_move_ready = 1'b0;
      mg_mate = 1'b0;
      check_value("control outputs", {soft_reset, clear_moves, new_board_valid}, 3'b000);
      read_check(REG_CONTROL, 32'h0, "rdata control");
   endtask

   task automatic test_move_result();
      mg_eval = 24'hFF_FC18; // -1000
      read_check(REG_EVAL, 32'hFFFF_FC18, "rdata eval");
      mg_eval = 24'h01_2345;
      read_check(REG_EVAL, 32'h0001_2345, "rdata eval");
      mg_move_count = 8'd37;
      read_check(REG_MOVE_COUNT, 32'd37, "rdata move count");
      mg_uci = {4'hA, 3'd6, 3'd5, 3'd3, 3'd7}; // Promotion, from file/rank, to file/rank
      read_check(REG_UCI, 32'h000A_6537, "rdata uci");
      mg_uci = {4'h5, 3'd7, 3'd7, 3'd7, 3'd7};
      read_check(REG_UCI, 32'h0005_7777, "rdata uci");
   endtask

   task automatic test_channel_order();
      logic [31:0] value;
      for (int i = 0; i < 9; i++)
      begin
         value = 32'd100 + 32'(i * 37);
         axi_write(REG_HALF_MOVE, value, i % 3, rand_delay());
         check_value("half_move", half_move, value[HALF_MOVE_WIDTH-1:0]);
         read_check(REG_HALF_MOVE, value, "rdata half move");
      end
   endtask

   task automatic test_unmapped();
      logic [BOARD_WIDTH-1:0] board_before;
      logic [30:0]            fields_before;
      board_before = board;
      fields_before = scalar_outputs();
      axi_write(10'd300, 32'hDEAD_BEEF, 0, rand_delay());
      check_value("board", board, board_before);
      check_value("generator outputs", scalar_outputs(), fields_before);
      read_check(REG_POSITION, 32'h0000_01B5, "rdata position");
      read_check(REG_MOVE_INDEX, 32'd42, "rdata move index");
      for (int n = 0; n < NUM_RANKS; n++)
         read_check(REG_BOARD_BASE + n, rank_word(n), $sformatf("rdata rank %0d", n));
      read_check(10'd300, 32'h0, "rdata unmapped word");
   endtask

   initial
   begin
      void'($urandom(32'h129d));
      rst_n = 1'b0;
      awaddr = '0;
      awprot = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = 4'hF;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arprot = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      mg_idle = 1'b0;
      mg_moves_ready = 1'b0;
      mg_move_ready = 1'b0;
      mg_stalemate = 1'b0;
      mg_mate = 1'b0;
      mg_move_count = '0;
      mg_eval = '0;
      mg_uci = '0;
      repeat (8)
         @(posedge clk);
      #1;
      rst_n = 1'b1;
      tick();
      test_reset();
      test_position_load();
      test_control_status();
      test_move_result();
      test_channel_order();
      test_unmapped();
      $display("Errors: %0d value, %0d protocol, %0d assertion", value_errors,
               protocol_errors, DUT.u_properties.failures);
      if (value_errors + protocol_errors + DUT.u_properties.failures == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* compile.f */
src/vchess_ctrl_pkg.sv
src/axi_write_capture.sv
src/ctrl_reg_bank.sv
src/axi_read_responder.sv
src/vchess_ctrl_top.sv
tb/vchess_ctrl_properties.sv
tb/tb_vchess_ctrl.sv
